// ==== Makefile ====
# Verilator flow for mmu_lite, the sim target passes only if the log holds the pass line

TOP := mmu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f mmu_lite.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f mmu_lite.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/mmu_assertions.sv ====
// concurrent protocol checks on the mmu_top ports
// attached to every mmu_top instance through the bind at the end

`timescale 1ns/1ps

module mmu_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic dtlb_hit_i,
  input logic dtlb_miss_i,
  input logic valid_i,
  input logic ex_valid_i
);

  // ----------------------------------------
  // reset and result checks
  // ----------------------------------------
  // first edge out of reset still sees the cleared request register
  reset_clear: assert property (@(posedge clk_i) $rose(rst_ni) |-> !valid_i && !ex_valid_i)
    else $error("result or exception valid right after reset");

  // an exception always rides on a valid result
  ex_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni) ex_valid_i |-> valid_i)
    else $error("exception reported without a valid result");

  // lookup strobes are exclusive
  hit_miss_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(dtlb_hit_i && dtlb_miss_i))
    else $error("tlb hit and miss in the same cycle");

  // results come exactly one cycle after their request
  valid_from_req: assert property (@(posedge clk_i) disable iff (!rst_ni) valid_i |-> $past(req_i))
    else $error("valid result without a request one cycle earlier");

endmodule

bind mmu_top mmu_assertions i_mmu_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_i       (req_i),
  .dtlb_hit_i  (dtlb_hit_o),
  .dtlb_miss_i (dtlb_miss_o),
  .valid_i     (valid_o),
  .ex_valid_i  (ex_valid_o)
);

// ==== bench/mmu_tb.sv ====
// testbench for mmu_top with a reference model of the tlb and the checks
// outputs are compared on every falling edge
// run through the Makefile sim target

`timescale 1ns/1ps

module mmu_tb;

  localparam int unsigned TLB_ENTRIES = 4;
  localparam int unsigned MAX_CYCLES  = 400;

  // pages used by the tests
  localparam logic [mmu_pkg::VPN_W-1:0] VPN_A = {9'h001, 9'h023, 9'h045};
  localparam logic [mmu_pkg::VPN_W-1:0] VPN_B = {9'h001, 9'h023, 9'h046};
  localparam logic [mmu_pkg::VPN_W-1:0] VPN_C = {9'h002, 9'h010, 9'h011};
  localparam logic [mmu_pkg::VPN_W-1:0] VPN_M = {9'h003, 9'h045, 9'h000};
  localparam logic [mmu_pkg::VPN_W-1:0] VPN_G = {9'h007, 9'h000, 9'h000};
  localparam logic [mmu_pkg::VPN_W-1:0] VPN_X = {9'h010, 9'h001, 9'h001};
  localparam logic [mmu_pkg::VPN_W-1:0] VPN_D = {9'h010, 9'h001, 9'h002};
  localparam logic [mmu_pkg::VPN_W-1:0] VPN_U = {9'h010, 9'h001, 9'h003};
  localparam logic [mmu_pkg::VPN_W-1:0] VPN_Z = {9'h1aa, 9'h0bb, 9'h0cc};

  logic                        clk_i;
  logic                        rst_ni;
  logic                        en_translation_i;
  logic                        req_i;
  logic                        is_store_i;
  logic                        misaligned_i;
  logic [mmu_pkg::VLEN-1:0]    vaddr_i;
  logic                        refill_i;
  logic [mmu_pkg::VPN_W-1:0]   refill_vpn_i;
  logic [mmu_pkg::PTE_W-1:0]   refill_pte_i;
  logic [1:0]                  refill_level_i;
  logic                        flush_i;
  logic [1:0]                  priv_lvl_i;
  logic                        sum_i;
  logic                        mxr_i;
  logic                        dtlb_hit_o;
  logic                        dtlb_miss_o;
  logic                        valid_o;
  logic [mmu_pkg::PLEN-1:0]    paddr_o;
  logic                        ex_valid_o;
  logic [3:0]                  ex_cause_o;
  logic [mmu_pkg::VLEN-1:0]    ex_tval_o;

  // ----------------------------------------
  // reference model state
  // ----------------------------------------
  logic                      m_valid [TLB_ENTRIES];
  logic [mmu_pkg::VPN_W-1:0] m_vpn   [TLB_ENTRIES];
  logic [mmu_pkg::PTE_W-1:0] m_pte   [TLB_ENTRIES];
  logic [1:0]                m_lvl   [TLB_ENTRIES];
  int unsigned               m_ptr;

  // prediction for the current request (d) and the one in check (q)
  logic                     exp_valid_d;
  logic                     exp_valid_q;
  logic                     exp_ex_d;
  logic                     exp_ex_q;
  logic [3:0]               exp_cause_d;
  logic [3:0]               exp_cause_q;
  logic [mmu_pkg::PLEN-1:0] exp_paddr_d;
  logic [mmu_pkg::PLEN-1:0] exp_paddr_q;
  logic [mmu_pkg::VLEN-1:0] exp_tval_d;
  logic [mmu_pkg::VLEN-1:0] exp_tval_q;
  string                    exp_name_d;
  string                    exp_name_q;

  string       test_name;
  integer      seed;
  int unsigned cycles = 0;

  mmu_top #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) dut (.*);

  always #50 clk_i = ~clk_i;

  // ----------------------------------------
  // model helpers
  // ----------------------------------------
  // lowest mirror entry covering va or -1 when none
  function automatic int lookup_entry(logic [mmu_pkg::VLEN-1:0] va);
    logic [mmu_pkg::VPN_W-1:0] vpn;
    int                        found;
    vpn   = va[38:12];
    found = -1;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (m_valid[i] && (vpn[26:18] == m_vpn[i][26:18]) &&
          (m_lvl[i] == mmu_pkg::LVL_1G || vpn[17:9] == m_vpn[i][17:9]) &&
          (m_lvl[i] != mmu_pkg::LVL_4K || vpn[8:0] == m_vpn[i][8:0])) begin
        found = i;
      end
    end
    return found;
  endfunction

  function automatic logic perm_fault(logic [mmu_pkg::PTE_W-1:0] pte, logic store,
                                      logic [1:0] priv, logic sum, logic mxr);
    logic can_read;
    logic bad_priv;
    can_read = pte[mmu_pkg::PTE_R] || (pte[mmu_pkg::PTE_X] && mxr);
    if (priv == mmu_pkg::PRIV_U) begin
      bad_priv = !pte[mmu_pkg::PTE_U];
    end else begin
      bad_priv = pte[mmu_pkg::PTE_U] && !sum;
    end
    if (!pte[mmu_pkg::PTE_V] || !pte[mmu_pkg::PTE_A] || bad_priv) begin
      return 1'b1;
    end
    return store ? (!pte[mmu_pkg::PTE_WR] || !pte[mmu_pkg::PTE_D]) : !can_read;
  endfunction

  // valid and accessed always set while the rest is chosen per page
  function automatic logic [mmu_pkg::PTE_W-1:0] make_pte(logic [mmu_pkg::PPN_W-1:0] ppn,
      logic r, logic w, logic x, logic u, logic d);
    logic [9:0] flags;
    flags                  = '0;
    flags[mmu_pkg::PTE_V]  = 1'b1;
    flags[mmu_pkg::PTE_A]  = 1'b1;
    flags[mmu_pkg::PTE_R]  = r;
    flags[mmu_pkg::PTE_WR] = w;
    flags[mmu_pkg::PTE_X]  = x;
    flags[mmu_pkg::PTE_U]  = u;
    flags[mmu_pkg::PTE_D]  = d;
    return {ppn, flags};
  endfunction

  task automatic check_value(string test, string what, logic [63:0] expected,
                             logic [63:0] actual);
    assert (expected === actual) else begin
      $display("FAIL %s: %s expected %h actual %h", test, what, expected, actual);
      $display("Test failures found");
      $fatal(1, "output mismatch");
    end
  endtask

  // ----------------------------------------
  // checker and prediction at mid cycle
  // ----------------------------------------
  always @(negedge clk_i) begin : check_outputs
    int                        idx;
    logic                      fault;
    logic [mmu_pkg::PPN_W-1:0] ppn;
    if (rst_ni) begin
      // result of last cycle's request
      check_value(exp_name_q, "valid_o", 64'(exp_valid_q), 64'(valid_o));
      check_value(exp_name_q, "ex_valid_o", 64'(exp_ex_q), 64'(ex_valid_o));
      if (exp_valid_q && !exp_ex_q) begin
        check_value(exp_name_q, "paddr_o", 64'(exp_paddr_q), 64'(paddr_o));
      end
      if (exp_ex_q) begin
        check_value(exp_name_q, "ex_cause_o", 64'(exp_cause_q), 64'(ex_cause_o));
        check_value(exp_name_q, "ex_tval_o", 64'(exp_tval_q), 64'(ex_tval_o));
      end
      // lookup strobes of the current request
      idx = lookup_entry(vaddr_i);
      check_value(test_name, "dtlb_hit_o",
                  64'(en_translation_i ? (req_i && idx >= 0) : 1'b1), 64'(dtlb_hit_o));
      check_value(test_name, "dtlb_miss_o",
                  64'(req_i && en_translation_i && idx < 0), 64'(dtlb_miss_o));
      // what the check stage must show next cycle
      fault       = 1'b0;
      exp_paddr_d = {{(mmu_pkg::PLEN - mmu_pkg::VLEN){1'b0}}, vaddr_i};
      if (en_translation_i && idx >= 0) begin
        fault = perm_fault(m_pte[idx], is_store_i, priv_lvl_i, sum_i, mxr_i);
        ppn   = m_pte[idx][mmu_pkg::PTE_W-1:mmu_pkg::PTE_PPN_LSB];
        case (m_lvl[idx])
          mmu_pkg::LVL_1G: exp_paddr_d = {ppn[43:18], vaddr_i[29:0]};
          mmu_pkg::LVL_2M: exp_paddr_d = {ppn[43:9], vaddr_i[20:0]};
          default:         exp_paddr_d = {ppn, vaddr_i[11:0]};
        endcase
      end
      exp_name_d  = test_name;
      exp_valid_d = req_i && (!en_translation_i || idx >= 0 || misaligned_i);
      exp_ex_d    = req_i && (misaligned_i || fault);
      exp_tval_d  = vaddr_i;
      if (misaligned_i) begin
        exp_cause_d = is_store_i ? mmu_pkg::CAUSE_ST_MISALIGNED : mmu_pkg::CAUSE_LD_MISALIGNED;
      end else begin
        exp_cause_d = is_store_i ? mmu_pkg::CAUSE_ST_PAGE_FAULT : mmu_pkg::CAUSE_LD_PAGE_FAULT;
      end
    end
  end

  // model registers where flush beats refill
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        m_valid[i] = 1'b0;
      end
      m_ptr       = 0;
      exp_valid_q = 1'b0;
      exp_ex_q    = 1'b0;
      exp_name_q  = "reset";
    end else begin
      exp_valid_q = exp_valid_d;
      exp_ex_q    = exp_ex_d;
      exp_cause_q = exp_cause_d;
      exp_paddr_q = exp_paddr_d;
      exp_tval_q  = exp_tval_d;
      exp_name_q  = exp_name_d;
      if (flush_i) begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
          m_valid[i] = 1'b0;
        end
      end else if (refill_i) begin
        m_valid[m_ptr] = 1'b1;
        m_vpn[m_ptr]   = refill_vpn_i;
        m_pte[m_ptr]   = refill_pte_i;
        m_lvl[m_ptr]   = refill_level_i;
        m_ptr          = (m_ptr + 1) % TLB_ENTRIES;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic next_cycle();
    @(posedge clk_i);
    #5;
  endtask

  task automatic send_req(logic store, logic mis, logic [mmu_pkg::VLEN-1:0] va);
    req_i        = 1'b1;
    is_store_i   = store;
    misaligned_i = mis;
    vaddr_i      = va;
    next_cycle();
    req_i        = 1'b0;
    is_store_i   = 1'b0;
    misaligned_i = 1'b0;
  endtask

  task automatic refill_page(logic [mmu_pkg::VPN_W-1:0] vpn, logic [mmu_pkg::PTE_W-1:0] pte,
                             logic [1:0] lvl);
    refill_i       = 1'b1;
    refill_vpn_i   = vpn;
    refill_pte_i   = pte;
    refill_level_i = lvl;
    next_cycle();
    refill_i       = 1'b0;
  endtask

  task automatic flush_tlb();
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
  endtask

  initial begin
    logic [31:0] rnd;
    seed             = 87;
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    en_translation_i = 1'b0;
    req_i            = 1'b0;
    is_store_i       = 1'b0;
    misaligned_i     = 1'b0;
    vaddr_i          = '0;
    refill_i         = 1'b0;
    refill_vpn_i     = '0;
    refill_pte_i     = '0;
    refill_level_i   = mmu_pkg::LVL_4K;
    flush_i          = 1'b0;
    priv_lvl_i       = mmu_pkg::PRIV_S;
    sum_i            = 1'b0;
    mxr_i            = 1'b0;
    test_name        = "reset";
    repeat (3) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    next_cycle();

    // bare mode passes the address through
    test_name = "bare";
    rnd = $random(seed);
    send_req(1'b0, 1'b0, {rnd, 7'h55});
    send_req(1'b1, 1'b0, {rnd[6:0], rnd});

    // miss, refill, retry and back to back
    test_name        = "miss_refill";
    en_translation_i = 1'b1;
    rnd = $random(seed);
    send_req(1'b0, 1'b0, {VPN_A, rnd[11:0]});
    refill_page(VPN_A, make_pte(44'h000_0123_4567, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1), mmu_pkg::LVL_4K);
    send_req(1'b0, 1'b0, {VPN_A, rnd[11:0]});
    refill_page(VPN_B, make_pte(44'h00a_bcde_f012, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1), mmu_pkg::LVL_4K);
    send_req(1'b0, 1'b0, {VPN_A, rnd[23:12]});
    send_req(1'b1, 1'b0, {VPN_B, rnd[31:20]});
    send_req(1'b0, 1'b0, {VPN_B, rnd[11:0]});
    // lookup in the refill cycle still sees the old contents
    test_name      = "refill_same_cycle";
    refill_i       = 1'b1;
    refill_vpn_i   = VPN_C;
    refill_pte_i   = make_pte(44'h000_0000_0c0c, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
    refill_level_i = mmu_pkg::LVL_4K;
    send_req(1'b0, 1'b0, {VPN_C, 12'h010});
    refill_i = 1'b0;
    send_req(1'b0, 1'b0, {VPN_C, 12'h010});

    // megapage lands in entry 3 and gigapage wraps to entry 0
    test_name = "superpage";
    flush_tlb();
    refill_page(VPN_M, make_pte(44'h000_1234_55ff, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1), mmu_pkg::LVL_2M);
    refill_page(VPN_G, make_pte(44'h0ab_cdef_fff3, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1), mmu_pkg::LVL_1G);
    rnd = $random(seed);
    send_req(1'b0, 1'b0, {VPN_M[26:9], rnd[8:0], rnd[20:9]});
    send_req(1'b1, 1'b0, {VPN_M[26:9], rnd[17:9], rnd[11:0]});
    send_req(1'b0, 1'b0, {VPN_G[26:18], rnd[17:0], rnd[29:18]});
    send_req(1'b1, 1'b0, {VPN_G[26:18], rnd[31:14], rnd[11:0]});

    // permission faults in S and U mode
    test_name = "perm_fault";
    refill_page(VPN_X, make_pte(44'h000_0000_1001, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0), mmu_pkg::LVL_4K);
    refill_page(VPN_D, make_pte(44'h000_0000_1002, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0), mmu_pkg::LVL_4K);
    refill_page(VPN_U, make_pte(44'h000_0000_1003, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1), mmu_pkg::LVL_4K);
    rnd = $random(seed);
    send_req(1'b0, 1'b0, {VPN_X, rnd[11:0]});
    send_req(1'b1, 1'b0, {VPN_D, rnd[11:0]});
    send_req(1'b0, 1'b0, {VPN_D, rnd[23:12]});
    send_req(1'b0, 1'b0, {VPN_U, rnd[11:0]});
    priv_lvl_i = mmu_pkg::PRIV_U;
    send_req(1'b0, 1'b0, {VPN_G[26:18], rnd[29:0]});
    send_req(1'b1, 1'b0, {VPN_G[26:18], rnd[31:2]});
    send_req(1'b0, 1'b0, {VPN_U, rnd[31:20]});
    // sum opens user pages and mxr opens execute-only pages
    test_name  = "perm_override";
    priv_lvl_i = mmu_pkg::PRIV_S;
    sum_i      = 1'b1;
    send_req(1'b1, 1'b0, {VPN_U, rnd[11:0]});
    mxr_i = 1'b1;
    send_req(1'b0, 1'b0, {VPN_X, rnd[11:0]});
    sum_i = 1'b0;
    mxr_i = 1'b0;

    // misaligned beats page fault, miss and bypass
    test_name = "misaligned";
    send_req(1'b0, 1'b1, {VPN_X, rnd[11:0]});
    send_req(1'b1, 1'b1, {VPN_D, rnd[11:0]});
    send_req(1'b0, 1'b1, {VPN_Z, rnd[11:0]});
    en_translation_i = 1'b0;
    send_req(1'b1, 1'b1, {rnd, 7'h21});
    en_translation_i = 1'b1;

    // flush clears entries and wins over a refill in the same cycle
    test_name = "flush";
    flush_tlb();
    send_req(1'b0, 1'b0, {VPN_U, rnd[11:0]});
    flush_i = 1'b1;
    refill_page(VPN_A, make_pte(44'h000_0123_4567, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1), mmu_pkg::LVL_4K);
    flush_i = 1'b0;
    send_req(1'b0, 1'b0, {VPN_A, rnd[11:0]});

    // one page more than entries evicts the oldest
    test_name = "round_robin";
    for (int i = 0; i <= TLB_ENTRIES; i++) begin
      refill_page({9'h0f0, 9'h000, 9'(i)},
                  make_pte(44'(i + 'h200), 1'b1, 1'b1, 1'b0, 1'b0, 1'b1), mmu_pkg::LVL_4K);
    end
    for (int i = 0; i <= TLB_ENTRIES; i++) begin
      send_req(1'b0, 1'b0, {9'h0f0, 9'h000, 9'(i), 12'h0a8});
    end

    // drain the check stage
    next_cycle();
    next_cycle();
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== design/dtlb.sv ====
// fully associative data tlb with zero cycle lookup
// refilled and flushed from outside, round-robin victim selection

`timescale 1ns/1ps

module dtlb #(
  parameter int unsigned TLB_ENTRIES = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        en_translation_i,
  input  logic                        req_i,
  input  logic                        is_store_i,
  input  logic                        misaligned_i,
  input  logic [mmu_pkg::VLEN-1:0]    vaddr_i,
  input  logic                        refill_i,
  input  logic [mmu_pkg::VPN_W-1:0]   refill_vpn_i,
  input  logic [mmu_pkg::PTE_W-1:0]   refill_pte_i,
  input  logic [1:0]                  refill_level_i,
  input  logic                        flush_i,
  output logic                        dtlb_hit_o,
  output logic                        dtlb_miss_o,
  tlb_lookup_if.tx                    lu
);

  localparam int unsigned IDX_W = $clog2(TLB_ENTRIES);

  // entry state, only valid bits are control
  logic [TLB_ENTRIES-1:0]    valid_q;
  logic [mmu_pkg::VPN_W-1:0] vpn_q   [TLB_ENTRIES];
  logic [mmu_pkg::PTE_W-1:0] pte_q   [TLB_ENTRIES];
  logic [1:0]                level_q [TLB_ENTRIES];
  logic [IDX_W-1:0]          repl_ptr_q;

  logic [TLB_ENTRIES-1:0] entry_match;
  logic                   match;
  logic [IDX_W-1:0]       hit_idx;
  logic                   lu_hit;

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      // vpn[2] always compared
      entry_match[i] = valid_q[i] && (vpn_q[i][26:18] == vaddr_i[38:30]);
      // vpn[1] unless gigapage
      if (level_q[i] != mmu_pkg::LVL_1G) begin
        entry_match[i] = entry_match[i] && (vpn_q[i][17:9] == vaddr_i[29:21]);
      end
      // vpn[0] only for 4K pages
      if (level_q[i] != mmu_pkg::LVL_1G && level_q[i] != mmu_pkg::LVL_2M) begin
        entry_match[i] = entry_match[i] && (vpn_q[i][8:0] == vaddr_i[20:12]);
      end
    end
  end

  // lowest matching index wins if aliases ever exist
  always_comb begin
    match   = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (!match && entry_match[i]) begin
        match   = 1'b1;
        hit_idx = IDX_W'(i);
      end
    end
  end

  // bare mode always reports a hit
  assign lu_hit      = en_translation_i ? (req_i && match) : 1'b1;
  assign dtlb_hit_o  = lu_hit;
  assign dtlb_miss_o = req_i && en_translation_i && !match;

  // lookup bundle towards the request register
  assign lu.req        = req_i;
  assign lu.is_store   = is_store_i;
  assign lu.misaligned = misaligned_i;
  assign lu.vaddr      = vaddr_i;
  assign lu.translate  = en_translation_i;
  assign lu.hit        = lu_hit;
  assign lu.pte        = (en_translation_i && match) ? pte_q[hit_idx] : '0;
  assign lu.is_2m      = en_translation_i && match && (level_q[hit_idx] == mmu_pkg::LVL_2M);
  assign lu.is_1g      = en_translation_i && match && (level_q[hit_idx] == mmu_pkg::LVL_1G);

  // ----------------------------------------
  // refill and flush
  // ----------------------------------------
  // flush beats refill, victim pointer only moves on an accepted refill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      repl_ptr_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (refill_i) begin
      valid_q[repl_ptr_q] <= 1'b1;
      // wraps on its own, entry count is a power of two
      repl_ptr_q          <= repl_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_i && !flush_i) begin
      vpn_q[repl_ptr_q]   <= refill_vpn_i;
      pte_q[repl_ptr_q]   <= refill_pte_i;
      level_q[repl_ptr_q] <= refill_level_i;
    end
  end

endmodule

// ==== design/fault_check.sv ====
// physical address assembly and load/store permission checks
// purely combinational on the registered request

`timescale 1ns/1ps

module fault_check (
  tlb_lookup_if.rx                   chk,
  input  logic [1:0]                 priv_lvl_i,
  input  logic                       sum_i,
  input  logic                       mxr_i,
  output logic                       valid_o,
  output logic [mmu_pkg::PLEN-1:0]   paddr_o,
  output logic                       ex_valid_o,
  output logic [3:0]                 ex_cause_o,
  output logic [mmu_pkg::VLEN-1:0]   ex_tval_o
);

  logic [mmu_pkg::PPN_W-1:0] ppn;
  logic                      readable;
  logic                      priv_err;
  logic                      ld_fault;
  logic                      st_fault;
  logic                      page_fault;

  assign ppn = chk.pte[mmu_pkg::PTE_W-1:mmu_pkg::PTE_PPN_LSB];

  // ----------------------------------------
  // address assembly
  // ----------------------------------------
  always_comb begin
    if (!chk.translate) begin
      // bare mode passes the zero extended address
      paddr_o = {{(mmu_pkg::PLEN - mmu_pkg::VLEN){1'b0}}, chk.vaddr};
    end else begin
      paddr_o = {ppn, chk.vaddr[11:0]};
      // megapage keeps vpn[0] from the virtual address
      if (chk.is_2m) begin
        paddr_o[20:12] = chk.vaddr[20:12];
      end
      // gigapage keeps vpn[1] and vpn[0]
      if (chk.is_1g) begin
        paddr_o[29:12] = chk.vaddr[29:12];
      end
    end
  end

  // ----------------------------------------
  // permission checks
  // ----------------------------------------
  // mxr makes execute-only pages readable
  assign readable = chk.pte[mmu_pkg::PTE_R] || (chk.pte[mmu_pkg::PTE_X] && mxr_i);

  // user pages need sum in S mode and supervisor pages are closed to U mode
  assign priv_err = ((priv_lvl_i == mmu_pkg::PRIV_U) && !chk.pte[mmu_pkg::PTE_U]) ||
                    ((priv_lvl_i == mmu_pkg::PRIV_S) && chk.pte[mmu_pkg::PTE_U] && !sum_i);

  assign ld_fault = !chk.pte[mmu_pkg::PTE_V] || !readable ||
                    !chk.pte[mmu_pkg::PTE_A] || priv_err;

  // stores also need the dirty bit already set
  assign st_fault = !chk.pte[mmu_pkg::PTE_V] || !chk.pte[mmu_pkg::PTE_WR] ||
                    !chk.pte[mmu_pkg::PTE_A] || !chk.pte[mmu_pkg::PTE_D] || priv_err;

  // only a real hit under translation can page fault
  assign page_fault = chk.translate && chk.hit && (chk.is_store ? st_fault : ld_fault);

  // ----------------------------------------
  // result and exception select
  // ----------------------------------------
  // a miss drops the request unless it is misaligned
  assign valid_o    = chk.req && (chk.hit || chk.misaligned);
  assign ex_valid_o = chk.req && (chk.misaligned || page_fault);

  always_comb begin
    ex_cause_o = '0;
    ex_tval_o  = '0;
    if (ex_valid_o) begin
      ex_tval_o = chk.vaddr;
      // misaligned has priority over page fault
      if (chk.misaligned) begin
        ex_cause_o = chk.is_store ? mmu_pkg::CAUSE_ST_MISALIGNED
                                  : mmu_pkg::CAUSE_LD_MISALIGNED;
      end else begin
        ex_cause_o = chk.is_store ? mmu_pkg::CAUSE_ST_PAGE_FAULT
                                  : mmu_pkg::CAUSE_LD_PAGE_FAULT;
      end
    end
  end

endmodule

// ==== design/mmu_pkg.sv ====
// shared widths and encodings for the Sv39 data translation path
// design and bench files use these through scoped names

package mmu_pkg;

  // ----------------------------------------
  // address and page number widths
  // ----------------------------------------
  localparam int unsigned VLEN  = 39;
  localparam int unsigned PLEN  = 56;
  localparam int unsigned VPN_W = 27;
  localparam int unsigned PPN_W = 44;

  // leaf pte as kept in the tlb
  // ppn sits directly above the ten flag bits
  localparam int unsigned PTE_W       = 54;
  localparam int unsigned PTE_PPN_LSB = 10;

  // ----------------------------------------
  // pte flag bit positions
  // ----------------------------------------
  localparam int unsigned PTE_V  = 0;
  localparam int unsigned PTE_R  = 1;
  localparam int unsigned PTE_WR = 2;
  localparam int unsigned PTE_X  = 3;
  localparam int unsigned PTE_U  = 4;
  // bit 5 is the global flag and stays unused without asid matching
  localparam int unsigned PTE_A  = 6;
  localparam int unsigned PTE_D  = 7;

  // ----------------------------------------
  // page level codes on the refill port
  // ----------------------------------------
  localparam logic [1:0] LVL_4K = 2'd0;
  localparam logic [1:0] LVL_2M = 2'd1;
  localparam logic [1:0] LVL_1G = 2'd2;

  // privilege levels seen by load/store checks
  localparam logic [1:0] PRIV_U = 2'd0;
  localparam logic [1:0] PRIV_S = 2'd1;

  // ----------------------------------------
  // exception cause codes
  // ----------------------------------------
  localparam logic [3:0] CAUSE_LD_MISALIGNED = 4'd4;
  localparam logic [3:0] CAUSE_ST_MISALIGNED = 4'd6;
  localparam logic [3:0] CAUSE_LD_PAGE_FAULT = 4'd13;
  localparam logic [3:0] CAUSE_ST_PAGE_FAULT = 4'd15;

endpackage

// ==== design/mmu_top.sv ====
// data side translation top, tlb lookup then request register then checks
// result for a request at edge N is valid after edge N+1

`timescale 1ns/1ps

module mmu_top #(
  parameter int unsigned TLB_ENTRIES = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        en_translation_i,
  input  logic                        req_i,
  input  logic                        is_store_i,
  input  logic                        misaligned_i,
  input  logic [mmu_pkg::VLEN-1:0]    vaddr_i,
  input  logic                        refill_i,
  input  logic [mmu_pkg::VPN_W-1:0]   refill_vpn_i,
  input  logic [mmu_pkg::PTE_W-1:0]   refill_pte_i,
  input  logic [1:0]                  refill_level_i,
  input  logic                        flush_i,
  input  logic [1:0]                  priv_lvl_i,
  input  logic                        sum_i,
  input  logic                        mxr_i,
  output logic                        dtlb_hit_o,
  output logic                        dtlb_miss_o,
  output logic                        valid_o,
  output logic [mmu_pkg::PLEN-1:0]    paddr_o,
  output logic                        ex_valid_o,
  output logic [3:0]                  ex_cause_o,
  output logic [mmu_pkg::VLEN-1:0]    ex_tval_o
);

  // registered privilege context
  logic [1:0] priv_lvl_q;
  logic       sum_q;
  logic       mxr_q;

  tlb_lookup_if lu_bus ();
  tlb_lookup_if chk_bus ();

  dtlb #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) i_dtlb (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .en_translation_i (en_translation_i),
    .req_i            (req_i),
    .is_store_i       (is_store_i),
    .misaligned_i     (misaligned_i),
    .vaddr_i          (vaddr_i),
    .refill_i         (refill_i),
    .refill_vpn_i     (refill_vpn_i),
    .refill_pte_i     (refill_pte_i),
    .refill_level_i   (refill_level_i),
    .flush_i          (flush_i),
    .dtlb_hit_o       (dtlb_hit_o),
    .dtlb_miss_o      (dtlb_miss_o),
    .lu               (lu_bus.tx)
  );

  req_stage i_req_stage (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .lu         (lu_bus.rx),
    .priv_lvl_i (priv_lvl_i),
    .sum_i      (sum_i),
    .mxr_i      (mxr_i),
    .chk        (chk_bus.tx),
    .priv_lvl_o (priv_lvl_q),
    .sum_o      (sum_q),
    .mxr_o      (mxr_q)
  );

  fault_check i_fault_check (
    .chk        (chk_bus.rx),
    .priv_lvl_i (priv_lvl_q),
    .sum_i      (sum_q),
    .mxr_i      (mxr_q),
    .valid_o    (valid_o),
    .paddr_o    (paddr_o),
    .ex_valid_o (ex_valid_o),
    .ex_cause_o (ex_cause_o),
    .ex_tval_o  (ex_tval_o)
  );

endmodule

// ==== design/req_stage.sv ====
// one cycle register between tlb lookup and fault checking
// privilege context is captured with the request it belongs to

`timescale 1ns/1ps

module req_stage (
  input  logic        clk_i,
  input  logic        rst_ni,
  tlb_lookup_if.rx    lu,
  input  logic [1:0]  priv_lvl_i,
  input  logic        sum_i,
  input  logic        mxr_i,
  tlb_lookup_if.tx    chk,
  output logic [1:0]  priv_lvl_o,
  output logic        sum_o,
  output logic        mxr_o
);

  // everything cleared so chk.req is low out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chk.req        <= 1'b0;
      chk.is_store   <= 1'b0;
      chk.misaligned <= 1'b0;
      chk.vaddr      <= '0;
      chk.translate  <= 1'b0;
      chk.hit        <= 1'b0;
      chk.pte        <= '0;
      chk.is_2m      <= 1'b0;
      chk.is_1g      <= 1'b0;
      priv_lvl_o     <= '0;
      sum_o          <= 1'b0;
      mxr_o          <= 1'b0;
    end else begin
      // request and lookup result
      chk.req        <= lu.req;
      chk.is_store   <= lu.is_store;
      chk.misaligned <= lu.misaligned;
      chk.vaddr      <= lu.vaddr;
      chk.translate  <= lu.translate;
      chk.hit        <= lu.hit;
      chk.pte        <= lu.pte;
      chk.is_2m      <= lu.is_2m;
      chk.is_1g      <= lu.is_1g;
      // context of the same cycle
      priv_lvl_o     <= priv_lvl_i;
      sum_o          <= sum_i;
      mxr_o          <= mxr_i;
    end
  end

endmodule

// ==== design/tlb_lookup_if.sv ====
// request plus its tlb lookup result, passed between pipeline stages
// tx drives the bundle, rx samples or consumes it

`timescale 1ns/1ps

interface tlb_lookup_if;

  // request side
  logic                     req;
  logic                     is_store;
  logic                     misaligned;
  logic [mmu_pkg::VLEN-1:0] vaddr;

  // lookup result
  // translate low means bare mode with hit forced high
  logic                      translate;
  logic                      hit;
  logic [mmu_pkg::PTE_W-1:0] pte;
  logic                      is_2m;
  logic                      is_1g;

  modport tx (
    output req,
    output is_store,
    output misaligned,
    output vaddr,
    output translate,
    output hit,
    output pte,
    output is_2m,
    output is_1g
  );

  modport rx (
    input req,
    input is_store,
    input misaligned,
    input vaddr,
    input translate,
    input hit,
    input pte,
    input is_2m,
    input is_1g
  );

endinterface

// ==== mmu_lite.f ====
design/mmu_pkg.sv
design/tlb_lookup_if.sv
design/dtlb.sv
design/req_stage.sv
design/fault_check.sv
design/mmu_top.sv
bench/mmu_assertions.sv
bench/mmu_tb.sv
